// ==== bench/i2c_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_tb;
  import i2c_pkg::*;

  localparam int sys_freq    = 40_000_000;
  localparam int scl_freq    = 2_500_000;
  localparam int q           = sys_freq / (4 * scl_freq);  // clocks per quarter
  localparam int table_rows  = 8;
  localparam int random_rows = 16;
  localparam int max_wait    = 100 * q + 50;  // cycles allowed for one transfer
  localparam int watchdog_ns = (table_rows + random_rows) * (80 * q + 20) * 10 * 2;

  typedef struct {
    string      name;
    logic [6:0] addr;
    logic       rd;
    logic [7:0] wdata;
    logic       chk;   // row checks the byte read
    logic [7:0] exp;
  } table_row_t;

  logic       clk;
  logic       rst;
  logic       req_valid;
  i2c_req_t   req;
  logic [7:0] rdata;
  logic       busy;
  logic       done;

  table_row_t rows [table_rows];
  logic [7:0] ref_mem [mem_depth];  // reference copy of the memory
  logic [7:0] last_rd;              // byte the last read returned
  logic [31:0] rng;

  i2c_top #(
    .sys_freq_hz (sys_freq),
    .scl_freq_hz (scl_freq)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rdata     (rdata),
    .busy      (busy),
    .done      (done)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    begin
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    begin
      if (exp !== act)
        abort_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    begin
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
    end
  endfunction

  task automatic set_row(input int idx, input string name, input logic [6:0] addr,
                         input logic rd, input logic [7:0] wdata, input logic chk,
                         input logic [7:0] exp);
    begin
      rows[idx].name  = name;
      rows[idx].addr  = addr;
      rows[idx].rd    = rd;
      rows[idx].wdata = wdata;
      rows[idx].chk   = chk;
      rows[idx].exp   = exp;
    end
  endtask

  task automatic fill_table;
    begin
      set_row(0, "rd_reset_0",   7'd0,   1'b1, 8'h00, 1'b1, 8'h00);
      set_row(1, "rd_reset_5",   7'd5,   1'b1, 8'h00, 1'b1, 8'h05);
      set_row(2, "rd_reset_127", 7'd127, 1'b1, 8'h00, 1'b1, 8'h7f);
      set_row(3, "wr_5",         7'd5,   1'b0, 8'ha3, 1'b0, 8'h00);
      set_row(4, "rd_5",         7'd5,   1'b1, 8'h00, 1'b1, 8'ha3);
      set_row(5, "rd_6",         7'd6,   1'b1, 8'h00, 1'b1, 8'h06);  // neighbor untouched
      set_row(6, "wr_127",       7'd127, 1'b0, 8'h5c, 1'b0, 8'h00);
      set_row(7, "rd_127",       7'd127, 1'b1, 8'h00, 1'b1, 8'h5c);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one transfer with a dropped second request while busy
  ////////////////////////////////////////////////////////////
  task automatic run_transfer(input string name, input i2c_req_t r, input logic chk,
                              input logic [7:0] exp);
    int         cycles;
    int         pulses;
    i2c_req_t   decoy;
    begin
      decoy.addr  = r.addr;
      decoy.rd    = 1'b0;
      decoy.wdata = ~r.wdata;
      @(negedge clk);
      check({name, " idle before request"}, 0, busy);
      @(posedge clk);
      req       <= r;
      req_valid <= 1'b1;
      @(posedge clk);  // taken on this edge
      req_valid <= 1'b0;
      @(negedge clk);
      check({name, " busy after accept"}, 1, busy);
      @(posedge clk);
      req       <= decoy;  // must be ignored
      req_valid <= 1'b1;
      @(posedge clk);
      req_valid <= 1'b0;
      req       <= r;
      cycles = 0;
      pulses = 0;
      @(negedge clk);
      while (!done)
      begin
        cycles++;
        if (cycles > max_wait)
          abort_run($sformatf("no done pulse within %0d cycles in test %s", max_wait, name));
        @(negedge clk);
      end
      pulses++;
      check({name, " busy low with done"}, 0, busy);
      repeat (8)
      begin
        @(negedge clk);
        if (done)
          pulses++;
      end
      check({name, " done pulses"}, 1, pulses);
      check({name, " busy after done"}, 0, busy);
      if (r.rd)
      begin
        if (chk)
          check({name, " rdata"}, exp, rdata);
        last_rd = ref_mem[r.addr];
      end
      else
      begin
        check({name, " rdata kept on write"}, last_rd, rdata);
        ref_mem[r.addr] = r.wdata;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    i2c_req_t r;
    clk       = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rng       = 32'd34;
    last_rd   = 8'h00;
    for (int i = 0; i < mem_depth; i++)
      ref_mem[i] = 8'(i);  // memory resets to its index
    fill_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("reset busy", 0, busy);
    check("reset done", 0, done);

    for (int i = 0; i < table_rows; i++)
    begin
      r.addr  = rows[i].addr;
      r.rd    = rows[i].rd;
      r.wdata = rows[i].wdata;
      run_transfer(rows[i].name, r, rows[i].chk, rows[i].exp);
    end

    for (int i = 0; i < random_rows; i++)
    begin
      rng     = xorshift(rng);
      r.addr  = rng[6:0];
      r.rd    = rng[7];
      r.wdata = rng[15:8];
      run_transfer($sformatf("random_%0d", i), r, 1'b1, ref_mem[r.addr]);
    end

    $display("** PASS **");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    abort_run("watchdog expired before all transfers completed");
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/i2c_pkg.sv
src/i2c_phase_timer.sv
src/i2c_master.sv
src/i2c_target.sv
src/i2c_byte_mem.sv
src/i2c_top.sv
bench/i2c_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the I2C testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module i2c_tb \
  -f flist.f -o i2c_sim \
  && ./obj_dir/i2c_sim \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== src/i2c_byte_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_mem (
  input  wire                            clk,
  input  wire                            rst,
  input  i2c_pkg::mem_req_t              mem_req,
  output logic [i2c_pkg::i2c_data_w-1:0] rdata
);
  import i2c_pkg::*;

  logic [i2c_data_w-1:0] mem [mem_depth];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < mem_depth; i++)
      begin
        mem[i] <= i2c_data_w'(i);  // each byte holds its index
      end
    end
    else if (mem_req.we)
    begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
  end

  assign rdata = mem[mem_req.addr];  // no read latency

endmodule

`default_nettype wire

// ==== src/i2c_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_master #(
  parameter int quarter_len = 4
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   req_valid,
  input  i2c_pkg::i2c_req_t                     req,
  input  wire                                   sda,
  output logic                                  scl,
  output logic                                  sda_pull,
  output logic [i2c_pkg::i2c_data_w-1:0]        rdata,
  output logic                                  busy,
  output logic                                  done
);
  import i2c_pkg::*;

  typedef enum logic [2:0] {
    st_idle, st_start, st_addr, st_ack_addr, st_write, st_read, st_ack_data, st_stop
  } state_t;

  state_t                state;
  phase_t                phase;
  logic                  bit_end;
  logic [2:0]            bit_cnt;  // wraps after 8 bits
  logic [i2c_data_w-1:0] tx_sh;    // msb goes out first
  logic [i2c_data_w-1:0] rx_sh;
  logic [i2c_data_w-1:0] wdata_q;
  logic                  rd_q;
  logic                  sda_smp;  // sda as seen late in high0
  logic                  pull_nxt;
  logic                  scl_high;

  i2c_phase_timer #(
    .quarter_len (quarter_len)
  ) phase_timer0 (
    .clk     (clk),
    .rst     (rst),
    .en      (state != st_idle),
    .phase   (phase),
    .bit_end (bit_end)
  );

  assign scl_high = (phase == ph_high0) || (phase == ph_high1);
  assign scl      = (state == st_idle || state == st_start) ? 1'b1 : scl_high;
  assign busy     = (state != st_idle);

  ////////////////////////////////////////////////////////////
  // sda level per state and phase, low0 holds the old level
  // so sda never moves on the same cycle as the scl fall
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    pull_nxt = sda_pull;
    case (state)
      st_idle:  pull_nxt = 1'b0;
      st_start: pull_nxt = scl_high;  // sda falls with scl high
      st_addr, st_write:
      begin
        if (phase != ph_low0)
          pull_nxt = ~tx_sh[7];
      end
      st_ack_addr, st_read, st_ack_data:
      begin
        if (phase != ph_low0)
          pull_nxt = 1'b0;  // target acks or drives, NACK after read
      end
      st_stop:
      begin
        if (phase == ph_low1 || phase == ph_high0)
          pull_nxt = 1'b1;
        else if (phase == ph_high1)
          pull_nxt = 1'b0;  // sda rises with scl high
      end
      default: pull_nxt = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= st_idle;
      bit_cnt  <= '0;
      tx_sh    <= '0;
      rx_sh    <= '0;
      wdata_q  <= '0;
      rd_q     <= 1'b0;
      sda_smp  <= 1'b1;
      sda_pull <= 1'b0;
      rdata    <= '0;
      done     <= 1'b0;
    end
    else
    begin
      done     <= 1'b0;
      sda_pull <= pull_nxt;
      if (phase == ph_high0)
        sda_smp <= sda;
      case (state)
        st_idle:
        begin
          if (req_valid)
          begin
            tx_sh   <= {req.addr, req.rd};
            rd_q    <= req.rd;
            wdata_q <= req.wdata;
            bit_cnt <= '0;
            state   <= st_start;
          end
        end
        st_start:
        begin
          if (bit_end)
            state <= st_addr;
        end
        st_addr, st_write:
        begin
          if (bit_end)
          begin
            tx_sh   <= {tx_sh[6:0], 1'b0};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= (state == st_addr) ? st_ack_addr : st_ack_data;
          end
        end
        st_ack_addr:
        begin
          if (bit_end)
          begin
            tx_sh <= wdata_q;
            state <= rd_q ? st_read : st_write;
          end
        end
        st_read:
        begin
          if (bit_end)
          begin
            rx_sh   <= {rx_sh[6:0], sda_smp};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= st_ack_data;
          end
        end
        st_ack_data:
        begin
          if (bit_end)
          begin
            if (rd_q)
              rdata <= rx_sh;
            state <= st_stop;
          end
        end
        st_stop:
        begin
          if (bit_end)
          begin
            state <= st_idle;
            done  <= 1'b1;  // same edge busy drops
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data may only move while scl is low, start and stop excepted
  a_sda_stable: assert property (@(posedge clk) disable iff (rst)
    (scl && $past(scl) && (sda_pull != $past(sda_pull)))
      |-> (state == st_start || state == st_stop));

endmodule

`default_nettype wire

// ==== src/i2c_phase_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_phase_timer #(
  parameter int quarter_len = 4
) (
  input  wire             clk,
  input  wire             rst,
  input  wire             en,
  output i2c_pkg::phase_t phase,
  output logic            bit_end
);
  import i2c_pkg::*;

  localparam int cnt_w = $clog2(quarter_len);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(quarter_len - 1);

  logic [cnt_w-1:0] cnt;  // cycles within the current quarter

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cnt   <= '0;
      phase <= ph_low0;
    end
    else if (!en)
    begin
      cnt   <= '0;  // park at start of a bit
      phase <= ph_low0;
    end
    else if (cnt == cnt_last)
    begin
      cnt   <= '0;
      phase <= phase_t'(phase + 2'd1);  // wraps high1 -> low0
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_end = en && (phase == ph_high1) && (cnt == cnt_last);

  // the target needs a few cycles per quarter to see each edge
  a_quarter_len: assert property (@(posedge clk) quarter_len >= 4);

endmodule

`default_nettype wire

// ==== src/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

  localparam int i2c_addr_w = 7;  // memory and device address bits
  localparam int i2c_data_w = 8;  // one data byte
  localparam int mem_depth  = 128;

  // user request into the controller
  typedef struct packed {
    logic [i2c_addr_w-1:0] addr;
    logic                  rd;     // 1 = read
    logic [i2c_data_w-1:0] wdata;
  } i2c_req_t;

  // target side access to the byte memory
  typedef struct packed {
    logic                  we;
    logic [i2c_addr_w-1:0] addr;
    logic [i2c_data_w-1:0] wdata;
  } mem_req_t;

  // quarter of one scl bit period
  typedef enum logic [1:0] {
    ph_low0  = 2'd0,
    ph_low1  = 2'd1,
    ph_high0 = 2'd2,
    ph_high1 = 2'd3
  } phase_t;

endpackage

`default_nettype wire

// ==== src/i2c_target.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_target (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            scl,
  input  wire                            sda,
  output logic                           sda_pull,
  output i2c_pkg::mem_req_t              mem_req,
  input  wire [i2c_pkg::i2c_data_w-1:0]  mem_rdata
);
  import i2c_pkg::*;

  typedef enum logic [2:0] {
    st_idle, st_addr, st_ack_addr, st_rx_data, st_ack_data, st_tx_data, st_wait_ack,
    st_wait_stop
  } state_t;

  state_t                state;
  logic                  scl_s1, scl_s2, scl_q;
  logic                  sda_s1, sda_s2, sda_q;
  logic                  scl_rise, scl_fall, start_det, stop_det;
  logic [i2c_data_w-1:0] sh;       // address, rx and tx byte
  logic [2:0]            bit_cnt;
  logic [i2c_addr_w-1:0] addr_q;
  logic                  rd_q;
  logic                  we_q;

  ////////////////////////////////////////////////////////////
  // bus synchronizer and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      scl_s1 <= 1'b1;  // idle bus is high
      scl_s2 <= 1'b1;
      scl_q  <= 1'b1;
      sda_s1 <= 1'b1;
      sda_s2 <= 1'b1;
      sda_q  <= 1'b1;
    end
    else
    begin
      scl_s1 <= scl;
      scl_s2 <= scl_s1;
      scl_q  <= scl_s2;
      sda_s1 <= sda;
      sda_s2 <= sda_s1;
      sda_q  <= sda_s2;
    end
  end

  assign scl_rise  = scl_s2 & ~scl_q;
  assign scl_fall  = ~scl_s2 & scl_q;
  assign start_det = scl_s2 & scl_q & sda_q & ~sda_s2;
  assign stop_det  = scl_s2 & scl_q & ~sda_q & sda_s2;

  assign mem_req = '{we: we_q, addr: addr_q, wdata: sh};

  ////////////////////////////////////////////////////////////
  // protocol FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= st_idle;
      sh       <= '0;
      bit_cnt  <= '0;
      addr_q   <= '0;
      rd_q     <= 1'b0;
      we_q     <= 1'b0;
      sda_pull <= 1'b0;
    end
    else
    begin
      we_q <= 1'b0;
      if (stop_det)
      begin
        state    <= st_idle;
        sda_pull <= 1'b0;
      end
      else
      begin
        case (state)
          st_idle:
          begin
            if (start_det)
            begin
              bit_cnt <= '0;
              state   <= st_addr;
            end
          end
          st_addr:
          begin
            if (scl_rise)
            begin
              sh      <= {sh[6:0], sda_s2};
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7)
              begin
                addr_q <= sh[6:0];  // upper seven bits of the byte
                rd_q   <= sda_s2;
                state  <= st_ack_addr;
              end
            end
          end
          // first fall starts the ack, second fall ends it
          st_ack_addr:
          begin
            if (scl_fall)
            begin
              if (!sda_pull)
                sda_pull <= 1'b1;
              else if (rd_q)
              begin
                sh       <= mem_rdata;
                sda_pull <= ~mem_rdata[7];  // first read bit
                state    <= st_tx_data;
              end
              else
              begin
                sda_pull <= 1'b0;
                state    <= st_rx_data;
              end
            end
          end
          st_rx_data:
          begin
            if (scl_rise)
            begin
              sh      <= {sh[6:0], sda_s2};
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7)
              begin
                we_q  <= 1'b1;  // one cycle store
                state <= st_ack_data;
              end
            end
          end
          st_ack_data:
          begin
            if (scl_fall)
            begin
              if (!sda_pull)
                sda_pull <= 1'b1;
              else
              begin
                sda_pull <= 1'b0;
                state    <= st_wait_stop;
              end
            end
          end
          st_tx_data:
          begin
            if (scl_fall)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7)
              begin
                sda_pull <= 1'b0;  // let the controller answer
                state    <= st_wait_ack;
              end
              else
              begin
                sda_pull <= ~sh[6];
                sh       <= {sh[6:0], 1'b0};
              end
            end
          end
          st_wait_ack:
          begin
            if (scl_fall)
              state <= st_wait_stop;
          end
          st_wait_stop: state <= st_wait_stop;
          default:      state <= st_idle;
        endcase
      end
    end
  end

  a_we_pulse: assert property (@(posedge clk) disable iff (rst) we_q |=> !we_q);

endmodule

`default_nettype wire

// ==== src/i2c_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_top #(
  parameter int sys_freq_hz = 40_000_000,
  parameter int scl_freq_hz = 2_500_000
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            req_valid,
  input  i2c_pkg::i2c_req_t              req,
  output logic [i2c_pkg::i2c_data_w-1:0] rdata,
  output logic                           busy,
  output logic                           done
);
  import i2c_pkg::*;

  localparam int quarter_len = sys_freq_hz / (4 * scl_freq_hz);  // clocks per quarter

  logic                  scl;
  logic                  sda;
  logic                  sda_pull_m;
  logic                  sda_pull_s;
  mem_req_t              mem_req;
  logic [i2c_data_w-1:0] mem_rdata;

  assign sda = ~(sda_pull_m | sda_pull_s);  // wired-AND open drain

  i2c_master #(
    .quarter_len (quarter_len)
  ) master0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .sda       (sda),
    .scl       (scl),
    .sda_pull  (sda_pull_m),
    .rdata     (rdata),
    .busy      (busy),
    .done      (done)
  );

  i2c_target target0 (
    .clk       (clk),
    .rst       (rst),
    .scl       (scl),
    .sda       (sda),
    .sda_pull  (sda_pull_s),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

  i2c_byte_mem mem0 (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .rdata   (mem_rdata)
  );

endmodule

`default_nettype wire
